//--- verilog.f
+incdir+verilog
verilog/core_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/core.sv
verif/core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module core_tb -f verilog.f -o core_sim

out=$(./obj_dir/core_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test completed successfully"

//--- verif/core_tb.sv
`include "core_defines.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_tests = 5;
    localparam int prog_words = 16;
    localparam logic [31:0] ecall_word = {25'd0, `OP_SYSTEM};

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic             imem_req;
    logic [`XLEN-1:0] imem_addr;
    logic             imem_ack = 1'b0;
    logic [`XLEN-1:0] imem_rdata = '0;
    logic             dmem_req;
    logic             dmem_we;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic             dmem_ack = 1'b0;
    logic [`XLEN-1:0] dmem_rdata = '0;
    logic             exit;
    logic [`XLEN-1:0] gp;

    // program table
    string       names [n_tests];
    logic [31:0] progs [n_tests][prog_words];
    logic [31:0] exp_gp [n_tests];
    logic [31:0] exp_addr [n_tests];
    logic [31:0] exp_data [n_tests];
    logic [31:0] prog_q [$];
    int          n_built = 0;
    int          cur = 0;

    logic [31:0] imem [prog_words];
    logic [31:0] dmem [64];
    logic [1:0]  delay_pool [1024];
    logic [9:0]  ipick = 10'd0;
    logic [9:0]  dpick = 10'd512;
    logic [1:0]  iwait;
    logic [1:0]  dwait;

    int          store_count;
    int          late_req;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    int          exit_low;
    int          value_errors = 0;
    int          other_errors = 0;

    core dut (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .exit       (exit),
        .gp         (gp)
    );

    always #4 clk = ~clk;

    // ******************************
    // rv32i encoders
    // ******************************
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm);
        return {imm[19:0], rd[4:0], `OP_LUI};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OP_JAL};
    endfunction

    // unused slots past the program hold ecall
    task automatic add_test(input string name, input logic [31:0] gp_val,
                            input logic [31:0] st_addr, input logic [31:0] st_data);
        for (int i = 0; i < prog_words; i++) begin
            progs[n_built][i] = (i < prog_q.size()) ? prog_q[i] : ecall_word;
        end
        names[n_built]    = name;
        exp_gp[n_built]   = gp_val;
        exp_addr[n_built] = st_addr;
        exp_data[n_built] = st_data;
        n_built++;
    endtask

    task automatic build_table();
        // the store behind the ecall must never reach dmem
        prog_q = '{i_type(`OP_IMM, 3'b000, 1, 0, 100), i_type(`OP_IMM, 3'b000, 2, 0, -7),
                   r_type(7'h00, 3'b000, 3, 1, 2), r_type(7'h20, 3'b000, 4, 1, 2),
                   r_type(7'h00, 3'b100, 5, 3, 4), r_type(7'h00, 3'b010, 6, 2, 1),
                   r_type(7'h00, 3'b111, 7, 4, 1), r_type(7'h00, 3'b110, 3, 5, 7),
                   r_type(7'h00, 3'b000, 3, 3, 6), s_type(3, 0, 16), ecall_word,
                   s_type(3, 0, 12)};
        add_test("alu_reg", 32'h0000_0077, 32'd16, 32'h0000_0077);
        prog_q = '{u_type(1, 'h12345), i_type(`OP_IMM, 3'b110, 2, 1, 'h678),
                   i_type(`OP_IMM, 3'b100, 3, 2, -1), i_type(`OP_IMM, 3'b111, 4, 3, 'h0f0),
                   r_type(7'h00, 3'b000, 3, 3, 4), s_type(3, 0, 20), ecall_word};
        add_test("imm_lui", 32'hedcb_aa07, 32'd20, 32'hedcb_aa07);
        // every instruction needs the one before it
        prog_q = '{i_type(`OP_IMM, 3'b000, 3, 0, 1), r_type(7'h00, 3'b000, 3, 3, 3),
                   r_type(7'h00, 3'b000, 3, 3, 3), i_type(`OP_IMM, 3'b000, 3, 3, 3),
                   r_type(7'h00, 3'b000, 3, 3, 3), i_type(`OP_IMM, 3'b100, 3, 3, 'h55),
                   s_type(3, 0, 24), ecall_word};
        add_test("raw_chain", 32'h0000_005b, 32'd24, 32'h0000_005b);
        prog_q = '{u_type(5, 'hcafe0), i_type(`OP_IMM, 3'b000, 5, 5, 'h123),
                   i_type(`OP_IMM, 3'b000, 6, 0, 32), s_type(5, 6, 8),
                   i_type(`OP_LOAD, 3'b010, 3, 6, 8), ecall_word, s_type(5, 0, 44)};
        add_test("store_load", 32'hcafe_0123, 32'd40, 32'hcafe_0123);
        // beq taken, bne falls through, jal links x3
        prog_q = '{i_type(`OP_IMM, 3'b000, 1, 0, 5), i_type(`OP_IMM, 3'b000, 2, 0, 5),
                   b_type(3'b000, 1, 2, 12), i_type(`OP_IMM, 3'b000, 3, 0, 'h111),
                   s_type(3, 0, 0), b_type(3'b001, 1, 2, 8), j_type(3, 12),
                   i_type(`OP_IMM, 3'b000, 3, 0, 'h222), s_type(3, 0, 4),
                   i_type(`OP_IMM, 3'b000, 3, 3, 'h100), s_type(3, 0, 28), ecall_word};
        add_test("branch_jal", 32'h0000_011c, 32'd28, 32'h0000_011c);
    endtask

    // ******************************
    // memory models
    // ******************************
    always @(posedge clk) begin
        if (rst) begin
            imem_ack <= 1'b0;
            iwait    <= delay_pool[ipick];
            ipick    <= ipick + 1'b1;
            for (int i = 0; i < prog_words; i++) begin
                imem[i] <= progs[cur][i];
            end
        end else if (imem_req && !imem_ack) begin
            if (iwait == 2'd0) begin
                imem_ack   <= 1'b1;
                imem_rdata <= imem[imem_addr[5:2]];
            end else begin
                iwait <= iwait - 1'b1;
            end
        end else if (!imem_req && imem_ack) begin
            imem_ack <= 1'b0;
            iwait    <= delay_pool[ipick];
            ipick    <= ipick + 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            dmem_ack    <= 1'b0;
            dwait       <= delay_pool[dpick];
            dpick       <= dpick + 1'b1;
            store_count <= 0;
            late_req    <= 0;
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= 32'hdead_0000 | (i * 4);
            end
        end else begin
            if (exit && dmem_req) begin
                late_req <= late_req + 1;
            end
            if (dmem_req && !dmem_ack) begin
                if (dwait == 2'd0) begin
                    dmem_ack <= 1'b1;
                    if (dmem_we) begin
                        dmem[dmem_addr[7:2]] <= dmem_wdata;
                        store_count          <= store_count + 1;
                        store_addr           <= dmem_addr;
                        store_data           <= dmem_wdata;
                    end else begin
                        dmem_rdata <= dmem[dmem_addr[7:2]];
                    end
                end else begin
                    dwait <= dwait - 1'b1;
                end
            end else if (!dmem_req && dmem_ack) begin
                dmem_ack <= 1'b0;
                dwait    <= delay_pool[dpick];
                dpick    <= dpick + 1'b1;
            end
        end
    end

    // ******************************
    // checks and sequencing
    // ******************************
    task automatic check_results(input int t);
        assert (gp === exp_gp[t]) else begin
            $display("Error: %s gp expected %08h actual %08h", names[t], exp_gp[t], gp);
            value_errors++;
        end
        assert (store_count == 1) else begin
            $display("Error: %s store count expected 1 actual %0d", names[t], store_count);
            value_errors++;
        end
        assert (store_addr === exp_addr[t]) else begin
            $display("Error: %s store address expected %08h actual %08h",
                     names[t], exp_addr[t], store_addr);
            value_errors++;
        end
        assert (store_data === exp_data[t]) else begin
            $display("Error: %s store data expected %08h actual %08h",
                     names[t], exp_data[t], store_data);
            value_errors++;
        end
        assert (exit_low == 0) else begin
            $display("%s: exit went low again after it was raised", names[t]);
            other_errors++;
        end
        assert (late_req == 0) else begin
            $display("%s: a data memory request was issued after exit", names[t]);
            other_errors++;
        end
    endtask

    initial begin
        void'($urandom(89866));
        for (int k = 0; k < 1024; k++) begin
            delay_pool[k] = 2'($urandom % 4);
        end
        build_table();
        for (int t = 0; t < n_tests; t++) begin
            @(posedge clk);
            cur <= t;
            rst <= 1'b1;
            repeat (8) @(posedge clk);
            rst <= 1'b0;
            while (exit !== 1'b1) begin
                @(posedge clk);
            end
            exit_low = 0;
            repeat (12) begin
                @(posedge clk);
                if (exit !== 1'b1) begin
                    exit_low++;
                end
            end
            check_results(t);
        end
        $display("%0d tests run, %0d value errors, %0d other errors",
                 n_tests, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // about 400 cycles per table entry
    initial begin
        repeat (n_tests * 400) @(posedge clk);
        $display("watchdog expired after %0d cycles, the core never finished", n_tests * 400);
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog/core.sv
`include "core_defines.svh"

module core (
    input  logic             clk,
    input  logic             rst,
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    input  logic             imem_ack,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             dmem_req,
    output logic             dmem_we,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    input  logic             dmem_ack,
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic             exit,
    output logic [`XLEN-1:0] gp
);
    import core_pkg::*;

    logic             mem_busy;
    logic             hazard_stall;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic             inst_valid;
    logic [`XLEN-1:0] inst_pc;
    logic [`XLEN-1:0] inst;
    dest_t            ex_dest;
    dest_t            mem_dest;
    dest_t            wb_dest;

    pipe_if #(.payload_t(id_ex_t))  id_ex ();
    pipe_if #(.payload_t(ex_mem_t)) ex_mem ();
    pipe_if #(.payload_t(mem_wb_t)) mem_wb ();
    regread_if rf ();

    // stall and flush
    assign id_ex.hold  = mem_busy;
    assign id_ex.kill  = redirect;
    assign ex_mem.hold = mem_busy;
    assign ex_mem.kill = redirect;
    assign mem_wb.hold = 1'b0;
    assign mem_wb.kill = 1'b0;

    assign ex_dest  = '{we: id_ex.valid && id_ex.data.reg_we, rd: id_ex.data.rd};
    assign mem_dest = '{we: ex_mem.valid && ex_mem.data.reg_we, rd: ex_mem.data.rd};
    assign wb_dest  = '{we: mem_wb.valid && mem_wb.data.reg_we, rd: mem_wb.data.rd};

    // ******************************
    // fetch
    // ******************************
    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .hold        (mem_busy || hazard_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_ack    (imem_ack),
        .imem_rdata  (imem_rdata),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst        (inst)
    );

    // ******************************
    // decode
    // ******************************
    decode_stage u_decode (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst         (inst),
        .hold         (id_ex.hold),
        .kill         (id_ex.kill),
        .hazard_stall (hazard_stall),
        .rf           (rf),
        .id_ex        (id_ex),
        .ex_dest      (ex_dest),
        .mem_dest     (mem_dest),
        .wb_dest      (wb_dest)
    );

    // ******************************
    // execute and memory
    // ******************************
    execute_stage u_execute (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .mem_busy   (mem_busy),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

    // ******************************
    // writeback
    // ******************************
    writeback_stage u_writeback (
        .clk         (clk),
        .rst         (rst),
        .mem_wb      (mem_wb),
        .rf          (rf),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .exit        (exit),
        .gp          (gp)
    );

endmodule

//--- verilog/writeback_stage.sv
`include "core_defines.svh"

module writeback_stage (
    input  logic             clk,
    input  logic             rst,
    pipe_if.dst              mem_wb,
    regread_if.server        rf,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc,
    output logic             exit,
    output logic [`XLEN-1:0] gp
);
    import core_pkg::*;

    logic [`XLEN-1:0] regs [`NREGS];
    mem_wb_t          op;
    logic             fire;
    logic             we;
    logic [`XLEN-1:0] wdata;

    assign op   = mem_wb.data;
    assign fire = mem_wb.valid && !mem_wb.kill;
    assign we   = fire && op.reg_we && (op.rd != 5'd0);

    always_comb begin
        case (op.wb_sel)
            WB_MEM:  wdata = op.load_data;
            WB_PC4:  wdata = op.pc + 4;
            default: wdata = op.alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            regs[op.rd] <= wdata;
        end
    end

    // same-cycle write is visible to decode, x0 reads zero
    always_comb begin
        rf.rs1_data = (we && op.rd == rf.rs1_addr) ? wdata : regs[rf.rs1_addr];
        rf.rs2_data = (we && op.rd == rf.rs2_addr) ? wdata : regs[rf.rs2_addr];
        if (rf.rs1_addr == 5'd0) begin
            rf.rs1_data = '0;
        end
        if (rf.rs2_addr == 5'd0) begin
            rf.rs2_data = '0;
        end
    end

    assign redirect    = fire && op.taken;
    assign redirect_pc = op.target;
    assign gp          = regs[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            exit <= 1'b0;
        end else if (fire && op.ecall) begin
            exit <= 1'b1;
        end
    end

    a_quiet_after_exit: assert property (@(posedge clk) disable iff (rst)
        exit |-> !fire);

endmodule

//--- verilog/memory_stage.sv
`include "core_defines.svh"

module memory_stage (
    input  logic             clk,
    input  logic             rst,
    pipe_if.dst              ex_mem,
    pipe_if.src              mem_wb,
    output logic             mem_busy,
    output logic             dmem_req,
    output logic             dmem_we,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    input  logic             dmem_ack,
    input  logic [`XLEN-1:0] dmem_rdata
);
    import core_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_WAIT_ACK, M_WAIT_REL} mstate_e;

    mstate_e          state;
    ex_mem_t          op;
    mem_wb_t          res;
    logic             is_access;
    logic             released;
    logic [`XLEN-1:0] load_data;

    assign op        = ex_mem.data;
    assign is_access = ex_mem.valid && !ex_mem.kill && (op.mem_read || op.mem_write);
    // access finishes once ack has dropped
    assign released  = (state == M_WAIT_REL) && !dmem_ack;
    assign mem_busy  = (is_access && !released) || mem_wb.hold;

    // ex_mem is held for the whole access, so these stay stable
    assign dmem_we    = op.mem_write;
    assign dmem_addr  = op.alu_result;
    assign dmem_wdata = op.store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= M_IDLE;
            dmem_req <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (is_access) begin
                        dmem_req <= 1'b1;
                        state    <= M_WAIT_ACK;
                    end
                end
                M_WAIT_ACK: begin
                    if (dmem_ack) begin
                        dmem_req  <= 1'b0;
                        load_data <= dmem_rdata;
                        state     <= M_WAIT_REL;
                    end
                end
                M_WAIT_REL: begin
                    if (!dmem_ack) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_comb begin
        res.pc         = op.pc;
        res.alu_result = op.alu_result;
        res.load_data  = load_data;
        res.taken      = op.taken;
        res.target     = op.target;
        res.reg_we     = op.reg_we;
        res.rd         = op.rd;
        res.wb_sel     = op.wb_sel;
        res.ecall      = op.ecall;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else if (!mem_wb.hold) begin
            mem_wb.valid <= ex_mem.valid && !ex_mem.kill && !mem_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wb.hold) begin
            mem_wb.data <= res;
        end
    end

    a_req_after_release: assert property (@(posedge clk) disable iff (rst)
        $rose(dmem_req) |-> !dmem_ack);

endmodule

//--- verilog/execute_stage.sv
`include "core_defines.svh"

module execute_stage (
    input logic clk,
    input logic rst,
    pipe_if.dst id_ex,
    pipe_if.src ex_mem
);
    import core_pkg::*;

    id_ex_t           op;
    ex_mem_t          res;
    logic [`XLEN-1:0] alu;
    logic             taken;

    assign op = id_ex.data;

    always_comb begin
        case (op.alu_op)
            ALU_ADD: alu = op.op1 + op.op2;
            ALU_SUB: alu = op.op1 - op.op2;
            ALU_AND: alu = op.op1 & op.op2;
            ALU_OR:  alu = op.op1 | op.op2;
            ALU_XOR: alu = op.op1 ^ op.op2;
            ALU_SLT: alu = {{(`XLEN-1){1'b0}}, $signed(op.op1) < $signed(op.op2)};
            default: alu = op.op2;
        endcase
    end

    // branch compare on rs1 against rs2
    always_comb begin
        case (op.br_kind)
            BR_EQ:   taken = (op.op1 == op.rs2_data);
            BR_NE:   taken = (op.op1 != op.rs2_data);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        res.pc         = op.pc;
        res.alu_result = alu;
        res.store_data = op.rs2_data;
        res.taken      = taken;
        res.target     = op.pc + op.imm_b;
        res.mem_read   = op.mem_read;
        res.mem_write  = op.mem_write;
        res.reg_we     = op.reg_we;
        res.rd         = op.rd;
        res.wb_sel     = op.wb_sel;
        res.ecall      = op.ecall;
    end

    always_ff @(posedge clk) begin
        if (rst || ex_mem.kill) begin
            ex_mem.valid <= 1'b0;
        end else if (!ex_mem.hold) begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_mem.hold) begin
            ex_mem.data <= res;
        end
    end

endmodule

//--- verilog/decode_stage.sv
`include "core_defines.svh"

module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst_pc,
    input  logic [`XLEN-1:0] inst,
    input  logic             hold,
    input  logic             kill,
    output logic             hazard_stall,
    regread_if.client        rf,
    pipe_if.src              id_ex,
    input  core_pkg::dest_t  ex_dest,
    input  core_pkg::dest_t  mem_dest,
    input  core_pkg::dest_t  wb_dest
);
    import core_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             use_rs1;
    logic             use_rs2;
    logic             known;
    logic             raw;
    logic             issue;
    logic             halted;
    id_ex_t           dec;

    function automatic logic pending(dest_t d, logic [4:0] r);
        return d.we && (d.rd == r) && (r != 5'd0);
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    always_comb begin
        dec          = '0;
        dec.pc       = inst_pc;
        dec.op1      = rf.rs1_data;
        dec.op2      = rf.rs2_data;
        dec.rs2_data = rf.rs2_data;
        dec.rd       = inst[11:7];
        dec.alu_op   = ALU_ADD;
        dec.br_kind  = BR_NONE;
        dec.wb_sel   = WB_ALU;
        known        = 1'b1;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        case (opcode)
            `OP_REG, `OP_IMM: begin
                use_rs1    = 1'b1;
                use_rs2    = (opcode == `OP_REG);
                dec.reg_we = 1'b1;
                if (opcode == `OP_IMM) begin
                    dec.op2 = imm_i;
                end
                case (funct3)
                    3'b000:  dec.alu_op = (use_rs2 && inst[30]) ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            `OP_LUI: begin
                dec.op2    = imm_u;
                dec.alu_op = ALU_PASS_B;
                dec.reg_we = 1'b1;
            end
            `OP_LOAD: begin
                use_rs1      = 1'b1;
                dec.op2      = imm_i;
                dec.mem_read = 1'b1;
                dec.reg_we   = 1'b1;
                dec.wb_sel   = WB_MEM;
            end
            `OP_STORE: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.op2       = imm_s;
                dec.mem_write = 1'b1;
            end
            `OP_BRANCH: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.imm_b   = imm_b;
                dec.br_kind = funct3[0] ? BR_NE : BR_EQ;
                known       = (funct3[2:1] == 2'b00);
            end
            `OP_JAL: begin
                dec.imm_b   = imm_j;
                dec.br_kind = BR_JAL;
                dec.reg_we  = 1'b1;
                dec.wb_sel  = WB_PC4;
            end
            `OP_SYSTEM: dec.ecall = 1'b1;
            default:    known = 1'b0;
        endcase
        // anything unrecognised travels as a nop
        if (!known) begin
            dec.reg_we  = 1'b0;
            dec.br_kind = BR_NONE;
        end
    end

    assign raw = (use_rs1 && (pending(ex_dest, rs1) || pending(mem_dest, rs1) ||
                              pending(wb_dest, rs1))) ||
                 (use_rs2 && (pending(ex_dest, rs2) || pending(mem_dest, rs2) ||
                              pending(wb_dest, rs2)));

    // after an ecall nothing younger leaves decode
    assign hazard_stall = halted || (inst_valid && raw);
    assign issue        = inst_valid && !hazard_stall;

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            id_ex.valid <= 1'b0;
            halted      <= 1'b0;
        end else if (!hold) begin
            id_ex.valid <= issue;
            if (issue && dec.ecall) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            id_ex.data <= dec;
        end
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (rst)
        issue && !hold && !kill |-> known);

endmodule

//--- verilog/fetch_stage.sv
`include "core_defines.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             hold,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    input  logic             imem_ack,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             inst_valid,
    output logic [`XLEN-1:0] inst_pc,
    output logic [`XLEN-1:0] inst
);
    typedef enum logic [1:0] {F_IDLE, F_WAIT_ACK, F_WAIT_REL} fstate_e;

    fstate_e          state;
    logic [`XLEN-1:0] pc;
    logic             stale;
    logic             slot_free;

    // output slot empties whenever decode takes it
    assign slot_free = !inst_valid || !hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= F_IDLE;
            pc         <= `RESET_PC;
            imem_req   <= 1'b0;
            stale      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (!hold || redirect) begin
                inst_valid <= 1'b0;
            end
            case (state)
                F_IDLE: begin
                    if (!redirect) begin
                        imem_req  <= 1'b1;
                        imem_addr <= pc;
                        pc        <= pc + 4;
                        stale     <= 1'b0;
                        state     <= F_WAIT_ACK;
                    end
                end
                F_WAIT_ACK: begin
                    // in-flight fetch on the old path, drop it on arrival
                    if (redirect) begin
                        stale <= 1'b1;
                    end
                    if (imem_ack && slot_free) begin
                        imem_req <= 1'b0;
                        state    <= F_WAIT_REL;
                        if (!stale && !redirect) begin
                            inst_valid <= 1'b1;
                            inst_pc    <= imem_addr;
                            inst       <= imem_rdata;
                        end
                    end
                end
                F_WAIT_REL: begin
                    if (!imem_ack) begin
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
            if (redirect) begin
                pc <= redirect_pc;
            end
        end
    end

    a_imem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        imem_req |=> $stable(imem_addr));

endmodule

//--- verilog/pipe_if.sv
`include "core_defines.svh"

// stage link, upstream owns valid and data
interface pipe_if #(
    parameter type payload_t = logic
) ();
    logic     valid;
    payload_t data;
    logic     hold;
    logic     kill;

    modport src (output valid, output data, input hold, input kill);
    modport dst (input valid, input data, input hold, input kill);
endinterface

// decode reads two operands from the register file
interface regread_if;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    modport client (output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);
    modport server (input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);
endinterface

//--- verilog/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JAL} br_kind_e;

    // pending destination, seen by the hazard check
    typedef struct packed {
        logic       we;
        logic [4:0] rd;
    } dest_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] op1;
        logic [`XLEN-1:0] op2;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] imm_b;
        alu_op_e          alu_op;
        br_kind_e         br_kind;
        logic             mem_read;
        logic             mem_write;
        logic             reg_we;
        logic [4:0]       rd;
        wb_sel_e          wb_sel;
        logic             ecall;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
        logic             taken;
        logic [`XLEN-1:0] target;
        logic             mem_read;
        logic             mem_write;
        logic             reg_we;
        logic [4:0]       rd;
        wb_sel_e          wb_sel;
        logic             ecall;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] load_data;
        logic             taken;
        logic [`XLEN-1:0] target;
        logic             reg_we;
        logic [4:0]       rd;
        wb_sel_e          wb_sel;
        logic             ecall;
    } mem_wb_t;

endpackage

//--- verilog/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define XLEN     32
`define NREGS    32
`define RESET_PC 32'h0000_0000

// rv32i major opcodes
`define OP_LUI    7'b0110111
`define OP_JAL    7'b1101111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_SYSTEM 7'b1110011

`endif
